// File: backend.f
common/cpu_params.sv
common/uop_types.sv
rtl/rename/free_list.sv
rtl/rename/id_stage.sv
rtl/int_rs.sv
rtl/int_fu.sv
rtl/rob.sv
rtl/prf.sv
rtl/backend_top.sv
testbench/backend_tb.sv

// File: Bender.yml
package:
  name: backend

sources:
  - common/cpu_params.sv
  - common/uop_types.sv
  - rtl/rename/free_list.sv
  - rtl/rename/id_stage.sv
  - rtl/int_rs.sv
  - rtl/int_fu.sv
  - rtl/rob.sv
  - rtl/prf.sv
  - rtl/backend_top.sv
  - target: simulation
    files:
      - testbench/backend_tb.sv

// File: testbench/backend_tb.sv
`timescale 1ns/1ps

module backend_tb
    import cpu_params::*;
();

    localparam int CLK_PERIOD  = 40;
    localparam int N_SEED      = 14;
    localparam int N_INDEP     = 100;
    localparam int N_CHAIN     = 100;
    localparam int N_X0        = 60;
    localparam int N_BURST     = 300;
    localparam int N_RECYCLE   = 80;
    localparam int TOTAL_INSTR = N_SEED + N_INDEP + N_CHAIN + N_X0 + N_BURST + N_RECYCLE;
    localparam int WATCHDOG_NS = (TOTAL_INSTR * 20 + 200) * CLK_PERIOD;

    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_LUI    = 7'b0110111;

    logic              clk = 1'b0;
    logic              rst_n_i;
    logic              fetch_valid_i;
    logic [31:0]       fetch_instr_i;
    logic              fetch_ready_o;
    logic              commit_valid_o;
    logic [ARCH_W-1:0] commit_rd_o;
    logic [XLEN-1:0]   commit_value_o;

    integer      seed = 70299;
    logic [31:0] arf [ARCH_REGS];
    logic [31:0] exp_rd_q [$];
    logic [31:0] exp_val_q [$];
    int          pass_count;
    int          fail_count;
    int          accept_count;
    int          commit_count;
    int          fails_before;
    int          stall_count;
    logic [4:0]  prev_rd;
    logic [4:0]  next_rd;

    backend_top #(
        .ROB_DEPTH (ROB_DEPTH_DEF),
        .RS_DEPTH  (RS_DEPTH_DEF)
    ) backend_top_inst (
        .clk            (clk),
        .rst_n_i        (rst_n_i),
        .fetch_valid_i  (fetch_valid_i),
        .fetch_instr_i  (fetch_instr_i),
        .fetch_ready_o  (fetch_ready_o),
        .commit_valid_o (commit_valid_o),
        .commit_rd_o    (commit_rd_o),
        .commit_value_o (commit_value_o)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    // ********************
    // helpers.
    task automatic check_value(input string name, input logic [31:0] exp, input logic [31:0] act);
        if (exp !== act) begin
            $display("[FAIL] %0t %s expected %h actual %h", $time, name, exp, act);
            fail_count++;
        end else begin
            pass_count++;
        end
    endtask

    function automatic int rand_below(input int n);
        return $unsigned($random(seed)) % n;
    endfunction

    function automatic logic [31:0] rand_alu(input logic [4:0] rd, input logic [4:0] rs1,
                                             input logic [4:0] rs2);
        logic [11:0] imm12;
        imm12 = 12'($random(seed));
        case (rand_below(12))
            0:  return {7'h00, rs2, rs1, 3'b000, rd, OPC_OP};
            1:  return {7'h20, rs2, rs1, 3'b000, rd, OPC_OP};
            2:  return {7'h00, rs2, rs1, 3'b111, rd, OPC_OP};
            3:  return {7'h00, rs2, rs1, 3'b110, rd, OPC_OP};
            4:  return {7'h00, rs2, rs1, 3'b100, rd, OPC_OP};
            5:  return {7'h00, rs2, rs1, 3'b010, rd, OPC_OP};
            6:  return {imm12, rs1, 3'b000, rd, OPC_OP_IMM};
            7:  return {imm12, rs1, 3'b111, rd, OPC_OP_IMM};
            8:  return {imm12, rs1, 3'b110, rd, OPC_OP_IMM};
            9:  return {imm12, rs1, 3'b100, rd, OPC_OP_IMM};
            10: return {imm12, rs1, 3'b010, rd, OPC_OP_IMM};
            default: return {20'($random(seed)), rd, OPC_LUI};
        endcase
    endfunction

    // loads, stores, jumps, shifts and sltiu are all outside the subset.
    function automatic logic [31:0] rand_noop(input logic [4:0] rd);
        logic [31:0] w;
        w        = $random(seed);
        w[11:7]  = rd;
        case (rand_below(6))
            0: w[6:0] = 7'b0000011;
            1: w[6:0] = 7'b0100011;
            2: w[6:0] = 7'b1100011;
            3: w[6:0] = 7'b1101111;
            4: w = {7'h00, w[24:15], 3'b001, rd, OPC_OP};
            default: w = {w[31:15], 3'b011, rd, OPC_OP_IMM};
        endcase
        return w;
    endfunction

    function automatic logic [31:0] basic_op(input logic [2:0] f3, input logic [31:0] a,
                                             input logic [31:0] b, output logic ok);
        ok = 1'b1;
        case (f3)
            3'b000: return a + b;
            3'b111: return a & b;
            3'b110: return a | b;
            3'b100: return a ^ b;
            3'b010: return {31'b0, $signed(a) < $signed(b)};
            default: begin
                ok = 1'b0;
                return 32'h0;
            end
        endcase
    endfunction

    // in-order reference model run when an instruction is accepted.
    task automatic model_accept(input logic [31:0] instr);
        logic [4:0]  rd;
        logic [2:0]  f3;
        logic [6:0]  f7;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] res;
        logic        ok;
        rd  = instr[11:7];
        f3  = instr[14:12];
        f7  = instr[31:25];
        a   = arf[instr[19:15]];
        ok  = 1'b1;
        res = '0;
        if (instr[6:0] == OPC_OP) begin
            b   = arf[instr[24:20]];
            res = basic_op(f3, a, b, ok);
            if (f7 == 7'h20 && f3 == 3'b000) begin
                res = a - b;
            end else if (f7 != 7'h00) begin
                ok = 1'b0;
            end
        end else if (instr[6:0] == OPC_OP_IMM) begin
            b   = {{20{instr[31]}}, instr[31:20]};
            res = basic_op(f3, a, b, ok);
        end else if (instr[6:0] == OPC_LUI) begin
            res = {instr[31:12], 12'h0};
        end else begin
            ok = 1'b0;
        end
        if (!ok || rd == 5'd0) begin
            rd  = '0;
            res = '0;
        end else begin
            arf[rd] = res;
        end
        exp_rd_q.push_back(32'(rd));
        exp_val_q.push_back(res);
        accept_count++;
    endtask

    task automatic send_instr(input logic [31:0] instr);
        fetch_valid_i = 1'b1;
        fetch_instr_i = instr;
        @(negedge clk);
        while (!fetch_ready_o) begin
            stall_count++;
            @(negedge clk);
        end
        model_accept(instr);
        @(posedge clk);
        #2;
    endtask

    task automatic finish_test(input string name);
        fetch_valid_i = 1'b0;
        while (exp_rd_q.size() != 0) begin
            @(posedge clk);
        end
        @(posedge clk);
        #2;
        $display("%s done, %0d errors", name, fail_count - fails_before);
        fails_before = fail_count;
    endtask

    // ********************
    // commit monitor.
    always @(negedge clk) begin
        if (rst_n_i && commit_valid_o) begin
            commit_count++;
            if (exp_rd_q.size() == 0) begin
                $display("ERROR at %0t: commit seen with no accepted instruction left", $time);
                fail_count++;
            end else begin
                check_value("commit_rd_o", exp_rd_q.pop_front(), 32'(commit_rd_o));
                check_value("commit_value_o", exp_val_q.pop_front(), commit_value_o);
            end
        end
    end

    initial begin
        #(WATCHDOG_NS);
        $display("ERROR: commits stalled, %0d of %0d accepted instructions committed",
                 commit_count, accept_count);
        $display("Finished with errors");
        $finish;
    end

    // ********************
    // test sequence.
    initial begin
        for (int i = 0; i < ARCH_REGS; i++) begin
            arf[i] = '0;
        end
        pass_count    = 0;
        fail_count    = 0;
        accept_count  = 0;
        commit_count  = 0;
        fails_before  = 0;
        stall_count   = 0;
        prev_rd       = '0;
        next_rd       = '0;
        rst_n_i       = 1'b0;
        fetch_valid_i = 1'b0;
        fetch_instr_i = '0;
        repeat (3) @(posedge clk);
        #2;
        rst_n_i = 1'b1;

        // idle state right after reset.
        @(negedge clk);
        check_value("fetch_ready_o", 32'd1, 32'(fetch_ready_o));
        check_value("commit_valid_o", 32'd0, 32'(commit_valid_o));
        @(posedge clk);
        #2;

        // seed x1..x7 with nonzero values first.
        for (int r = 1; r < 8; r++) begin
            send_instr({20'($random(seed)), 5'(r), OPC_LUI});
            send_instr({12'($random(seed)), 5'(r), 3'b000, 5'(r), OPC_OP_IMM});
        end
        for (int i = 0; i < N_INDEP; i++) begin
            send_instr(rand_alu(5'(8 + rand_below(8)), 5'(1 + rand_below(7)),
                                5'(1 + rand_below(7))));
        end
        finish_test("independent ALU operations");

        for (int i = 0; i < N_CHAIN; i++) begin
            send_instr(rand_alu(5'(1 + rand_below(3)), 5'(1 + rand_below(3)),
                                5'(1 + rand_below(3))));
        end
        finish_test("dependency chains");

        for (int i = 0; i < N_X0; i++) begin
            case (rand_below(3))
                0: send_instr(rand_alu(5'd0, 5'(rand_below(8)), 5'(rand_below(8))));
                1: send_instr(rand_noop(5'(rand_below(8))));
                default: send_instr(rand_alu(5'(1 + rand_below(7)), 5'd0, 5'd0));
            endcase
        end
        finish_test("x0 handling and no-ops");

        // each instruction reads the previous result so the station backs up.
        stall_count = 0;
        prev_rd     = 5'(1 + rand_below(7));
        for (int i = 0; i < N_BURST; i++) begin
            next_rd = 5'(1 + rand_below(7));
            send_instr(rand_alu(next_rd, prev_rd, 5'(rand_below(8))));
            prev_rd = next_rd;
        end
        if (stall_count == 0) begin
            $display("ERROR: fetch_ready_o never dropped during the burst");
            fail_count++;
        end
        finish_test("back-pressure burst");
        check_value("commit_count", 32'(accept_count), 32'(commit_count));

        // x5 and x6 each renamed 40 times against a 32-tag free list.
        for (int i = 0; i < N_RECYCLE / 2; i++) begin
            send_instr({12'($random(seed)), 5'd5, 3'b000, 5'd5, OPC_OP_IMM});
            send_instr({7'h00, 5'd5, 5'd6, 3'b100, 5'd6, OPC_OP});
        end
        finish_test("register recycling");

        check_value("commit_count", 32'(accept_count), 32'(commit_count));
        $display("checks passed %0d, checks failed %0d", pass_count, fail_count);
        if (fail_count == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

// File: rtl/backend_top.sv
`timescale 1ns/1ps

module backend_top
    import cpu_params::*;
    import uop_types::*;
#(
    parameter int ROB_DEPTH = ROB_DEPTH_DEF,
    parameter int RS_DEPTH  = RS_DEPTH_DEF
) (
    input  logic              clk,
    input  logic              rst_n_i,
    input  logic              fetch_valid_i,
    input  logic [31:0]       fetch_instr_i,
    output logic              fetch_ready_o,
    output logic              commit_valid_o,
    output logic [ARCH_W-1:0] commit_rd_o,
    output logic [XLEN-1:0]   commit_value_o
);

    // ********************
    // rename and dispatch.
    logic                fl_pop;
    logic                fl_empty;
    logic [PHY_W-1:0]    fl_tag;
    logic                fl_push;
    logic [PHY_W-1:0]    fl_push_tag;
    logic                rob_full;
    logic [ROB_ID_W-1:0] rob_tail;
    logic                rob_alloc;
    logic [ARCH_W-1:0]   rob_rd;
    logic [PHY_W-1:0]    rob_new_tag;
    logic [PHY_W-1:0]    rob_old_tag;
    logic                rs_full;
    logic                rs_insert;
    uop_t                rs_uop;
    logic [PHY_W-1:0]    src1_tag;
    logic [PHY_W-1:0]    src2_tag;
    logic                src1_ready;
    logic                src2_ready;
    logic [PHY_W-1:0]    alloc_tag;

    // ********************
    // issue and cdb.
    logic [PHY_W-1:0]    rd_tag1;
    logic [PHY_W-1:0]    rd_tag2;
    logic [XLEN-1:0]     rd_val1;
    logic [XLEN-1:0]     rd_val2;
    logic                issue_valid;
    alu_op_e             issue_op;
    logic [XLEN-1:0]     issue_a;
    logic [XLEN-1:0]     issue_b;
    logic [ROB_ID_W-1:0] issue_rob_id;
    logic [PHY_W-1:0]    issue_tag;
    logic                cdb_valid;
    logic [PHY_W-1:0]    cdb_tag;
    logic [ROB_ID_W-1:0] cdb_rob_id;
    logic [XLEN-1:0]     cdb_value;

    id_stage id_stage_inst (
        .clk           (clk),
        .rst_n_i       (rst_n_i),
        .fetch_valid_i (fetch_valid_i),
        .fetch_instr_i (fetch_instr_i),
        .fetch_ready_o (fetch_ready_o),
        .fl_empty_i    (fl_empty),
        .fl_tag_i      (fl_tag),
        .fl_pop_o      (fl_pop),
        .rob_full_i    (rob_full),
        .rob_tail_i    (rob_tail),
        .rob_alloc_o   (rob_alloc),
        .rob_rd_o      (rob_rd),
        .rob_new_tag_o (rob_new_tag),
        .rob_old_tag_o (rob_old_tag),
        .rs_full_i     (rs_full),
        .rs_insert_o   (rs_insert),
        .rs_uop_o      (rs_uop),
        .src1_tag_o    (src1_tag),
        .src2_tag_o    (src2_tag),
        .src1_ready_i  (src1_ready),
        .src2_ready_i  (src2_ready),
        .alloc_tag_o   (alloc_tag)
    );

    free_list free_list_inst (
        .clk        (clk),
        .rst_n_i    (rst_n_i),
        .pop_i      (fl_pop),
        .tag_o      (fl_tag),
        .empty_o    (fl_empty),
        .push_i     (fl_push),
        .push_tag_i (fl_push_tag)
    );

    int_rs #(
        .RS_DEPTH (RS_DEPTH)
    ) int_rs_inst (
        .clk            (clk),
        .rst_n_i        (rst_n_i),
        .insert_i       (rs_insert),
        .uop_i          (rs_uop),
        .full_o         (rs_full),
        .cdb_valid_i    (cdb_valid),
        .cdb_tag_i      (cdb_tag),
        .rd_tag1_o      (rd_tag1),
        .rd_tag2_o      (rd_tag2),
        .rd_val1_i      (rd_val1),
        .rd_val2_i      (rd_val2),
        .issue_valid_o  (issue_valid),
        .issue_op_o     (issue_op),
        .issue_a_o      (issue_a),
        .issue_b_o      (issue_b),
        .issue_rob_id_o (issue_rob_id),
        .issue_tag_o    (issue_tag)
    );

    int_fu int_fu_inst (
        .clk            (clk),
        .rst_n_i        (rst_n_i),
        .issue_valid_i  (issue_valid),
        .issue_op_i     (issue_op),
        .issue_a_i      (issue_a),
        .issue_b_i      (issue_b),
        .issue_rob_id_i (issue_rob_id),
        .issue_tag_i    (issue_tag),
        .cdb_valid_o    (cdb_valid),
        .cdb_tag_o      (cdb_tag),
        .cdb_rob_id_o   (cdb_rob_id),
        .cdb_value_o    (cdb_value)
    );

    rob #(
        .ROB_DEPTH (ROB_DEPTH)
    ) rob_inst (
        .clk             (clk),
        .rst_n_i         (rst_n_i),
        .alloc_i         (rob_alloc),
        .alloc_rd_i      (rob_rd),
        .alloc_new_tag_i (rob_new_tag),
        .alloc_old_tag_i (rob_old_tag),
        .full_o          (rob_full),
        .tail_o          (rob_tail),
        .cdb_valid_i     (cdb_valid),
        .cdb_rob_id_i    (cdb_rob_id),
        .cdb_value_i     (cdb_value),
        .fl_push_o       (fl_push),
        .fl_push_tag_o   (fl_push_tag),
        .commit_valid_o  (commit_valid_o),
        .commit_rd_o     (commit_rd_o),
        .commit_value_o  (commit_value_o)
    );

    // a free-list pop is the allocation of a new tag.
    prf prf_inst (
        .clk          (clk),
        .rst_n_i      (rst_n_i),
        .rd_tag1_i    (rd_tag1),
        .rd_tag2_i    (rd_tag2),
        .rd_val1_o    (rd_val1),
        .rd_val2_o    (rd_val2),
        .src1_tag_i   (src1_tag),
        .src2_tag_i   (src2_tag),
        .src1_ready_o (src1_ready),
        .src2_ready_o (src2_ready),
        .alloc_i      (fl_pop),
        .alloc_tag_i  (alloc_tag),
        .cdb_valid_i  (cdb_valid),
        .cdb_tag_i    (cdb_tag),
        .cdb_value_i  (cdb_value)
    );

endmodule

// File: rtl/prf.sv
`timescale 1ns/1ps

module prf
    import cpu_params::*;
(
    input  logic             clk,
    input  logic             rst_n_i,
    input  logic [PHY_W-1:0] rd_tag1_i,
    input  logic [PHY_W-1:0] rd_tag2_i,
    output logic [XLEN-1:0]  rd_val1_o,
    output logic [XLEN-1:0]  rd_val2_o,
    input  logic [PHY_W-1:0] src1_tag_i,
    input  logic [PHY_W-1:0] src2_tag_i,
    output logic             src1_ready_o,
    output logic             src2_ready_o,
    input  logic             alloc_i,
    input  logic [PHY_W-1:0] alloc_tag_i,
    input  logic             cdb_valid_i,
    input  logic [PHY_W-1:0] cdb_tag_i,
    input  logic [XLEN-1:0]  cdb_value_i
);

    logic [XLEN-1:0]      value_q [PHYS_REGS];
    logic [PHYS_REGS-1:0] ready_q;

    assign rd_val1_o = (rd_tag1_i == '0) ? '0 : value_q[rd_tag1_i];
    assign rd_val2_o = (rd_tag2_i == '0) ? '0 : value_q[rd_tag2_i];

    // a same-cycle broadcast counts as ready.
    assign src1_ready_o = ready_q[src1_tag_i] || (cdb_valid_i && cdb_tag_i == src1_tag_i);
    assign src2_ready_o = ready_q[src2_tag_i] || (cdb_valid_i && cdb_tag_i == src2_tag_i);

    // architectural state starts at zero.
    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            ready_q <= '1;
            for (int i = 0; i < PHYS_REGS; i++) begin
                value_q[i] <= '0;
            end
        end else begin
            if (cdb_valid_i) begin
                value_q[cdb_tag_i] <= cdb_value_i;
                ready_q[cdb_tag_i] <= 1'b1;
            end
            if (alloc_i) begin
                ready_q[alloc_tag_i] <= 1'b0;
            end
        end
    end

    a_no_cdb_tag0: assert property (@(posedge clk) disable iff (!rst_n_i)
        cdb_valid_i |-> (cdb_tag_i != '0))
        else $error("cdb wrote physical tag 0");

endmodule

// File: rtl/rob.sv
`timescale 1ns/1ps

module rob
    import cpu_params::*;
#(
    parameter int ROB_DEPTH = ROB_DEPTH_DEF
) (
    input  logic                clk,
    input  logic                rst_n_i,
    input  logic                alloc_i,
    input  logic [ARCH_W-1:0]   alloc_rd_i,
    input  logic [PHY_W-1:0]    alloc_new_tag_i,
    input  logic [PHY_W-1:0]    alloc_old_tag_i,
    output logic                full_o,
    output logic [ROB_ID_W-1:0] tail_o,
    input  logic                cdb_valid_i,
    input  logic [ROB_ID_W-1:0] cdb_rob_id_i,
    input  logic [XLEN-1:0]     cdb_value_i,
    output logic                fl_push_o,
    output logic [PHY_W-1:0]    fl_push_tag_o,
    output logic                commit_valid_o,
    output logic [ARCH_W-1:0]   commit_rd_o,
    output logic [XLEN-1:0]     commit_value_o
);

    logic [ROB_DEPTH-1:0] valid_q;
    logic [ROB_DEPTH-1:0] done_q;
    logic [ROB_ID_W-1:0]  head_q;
    logic [ROB_ID_W-1:0]  tail_q;
    logic [ARCH_W-1:0]    rd_q [ROB_DEPTH];
    logic [PHY_W-1:0]     old_tag_q [ROB_DEPTH];
    logic [XLEN-1:0]      value_q [ROB_DEPTH];

    function automatic logic [ROB_ID_W-1:0] next_ptr(input logic [ROB_ID_W-1:0] ptr);
        return (ptr == ROB_ID_W'(ROB_DEPTH - 1)) ? '0 : ptr + 1'b1;
    endfunction

    assign full_o         = valid_q[tail_q];
    assign tail_o         = tail_q;
    assign commit_valid_o = valid_q[head_q] && done_q[head_q];
    assign commit_rd_o    = rd_q[head_q];
    assign commit_value_o = value_q[head_q];
    assign fl_push_o      = commit_valid_o && (rd_q[head_q] != '0);
    assign fl_push_tag_o  = old_tag_q[head_q];

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            valid_q <= '0;
            done_q  <= '0;
            head_q  <= '0;
            tail_q  <= '0;
        end else begin
            if (cdb_valid_i) begin
                done_q[cdb_rob_id_i] <= 1'b1;
            end
            if (commit_valid_o) begin
                valid_q[head_q] <= 1'b0;
                head_q          <= next_ptr(head_q);
            end
            // tag 0 means no producer, so nothing will arrive on the cdb.
            if (alloc_i) begin
                valid_q[tail_q] <= 1'b1;
                done_q[tail_q]  <= (alloc_new_tag_i == '0);
                tail_q          <= next_ptr(tail_q);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (alloc_i) begin
            rd_q[tail_q]      <= alloc_rd_i;
            old_tag_q[tail_q] <= alloc_old_tag_i;
            value_q[tail_q]   <= '0;
        end
        if (cdb_valid_i) begin
            value_q[cdb_rob_id_i] <= cdb_value_i;
        end
    end

    a_cdb_allocated: assert property (@(posedge clk) disable iff (!rst_n_i)
        cdb_valid_i |-> valid_q[cdb_rob_id_i])
        else $error("cdb result for a free rob entry");

endmodule

// File: rtl/int_fu.sv
`timescale 1ns/1ps

module int_fu
    import cpu_params::*;
    import uop_types::*;
(
    input  logic                clk,
    input  logic                rst_n_i,
    input  logic                issue_valid_i,
    input  alu_op_e             issue_op_i,
    input  logic [XLEN-1:0]     issue_a_i,
    input  logic [XLEN-1:0]     issue_b_i,
    input  logic [ROB_ID_W-1:0] issue_rob_id_i,
    input  logic [PHY_W-1:0]    issue_tag_i,
    output logic                cdb_valid_o,
    output logic [PHY_W-1:0]    cdb_tag_o,
    output logic [ROB_ID_W-1:0] cdb_rob_id_o,
    output logic [XLEN-1:0]     cdb_value_o
);

    logic [XLEN-1:0] result;

    always_comb begin
        case (issue_op_i)
            ALU_ADD: result = issue_a_i + issue_b_i;
            ALU_SUB: result = issue_a_i - issue_b_i;
            ALU_AND: result = issue_a_i & issue_b_i;
            ALU_OR:  result = issue_a_i | issue_b_i;
            ALU_XOR: result = issue_a_i ^ issue_b_i;
            ALU_SLT: result = XLEN'($signed(issue_a_i) < $signed(issue_b_i));
            default: result = issue_b_i;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            cdb_valid_o <= 1'b0;
        end else begin
            cdb_valid_o <= issue_valid_i;
        end
    end

    always_ff @(posedge clk) begin
        cdb_tag_o    <= issue_tag_i;
        cdb_rob_id_o <= issue_rob_id_i;
        cdb_value_o  <= result;
    end

endmodule

// File: rtl/int_rs.sv
`timescale 1ns/1ps

module int_rs
    import cpu_params::*;
    import uop_types::*;
#(
    parameter int RS_DEPTH = RS_DEPTH_DEF
) (
    input  logic                clk,
    input  logic                rst_n_i,
    input  logic                insert_i,
    input  uop_t                uop_i,
    output logic                full_o,
    input  logic                cdb_valid_i,
    input  logic [PHY_W-1:0]    cdb_tag_i,
    output logic [PHY_W-1:0]    rd_tag1_o,
    output logic [PHY_W-1:0]    rd_tag2_o,
    input  logic [XLEN-1:0]     rd_val1_i,
    input  logic [XLEN-1:0]     rd_val2_i,
    output logic                issue_valid_o,
    output alu_op_e             issue_op_o,
    output logic [XLEN-1:0]     issue_a_o,
    output logic [XLEN-1:0]     issue_b_o,
    output logic [ROB_ID_W-1:0] issue_rob_id_o,
    output logic [PHY_W-1:0]    issue_tag_o
);

    localparam int IDX_W = $clog2(RS_DEPTH);

    logic [RS_DEPTH-1:0] valid_q;
    uop_t                entry_q [RS_DEPTH];
    logic [IDX_W-1:0]    age_q [RS_DEPTH];
    logic [IDX_W-1:0]    free_idx;
    logic [IDX_W-1:0]    sel_idx;
    logic [IDX_W-1:0]    sel_age;
    logic                sel_valid;

    assign full_o = &valid_q;

    always_comb begin
        free_idx = '0;
        for (int i = RS_DEPTH - 1; i >= 0; i--) begin
            if (!valid_q[i]) begin
                free_idx = IDX_W'(i);
            end
        end
    end

    // oldest entry with both sources ready.
    always_comb begin
        sel_valid = 1'b0;
        sel_idx   = '0;
        sel_age   = '0;
        for (int i = 0; i < RS_DEPTH; i++) begin
            if (valid_q[i] && entry_q[i].src1_rdy && entry_q[i].src2_rdy &&
                (!sel_valid || age_q[i] > sel_age)) begin
                sel_valid = 1'b1;
                sel_idx   = IDX_W'(i);
                sel_age   = age_q[i];
            end
        end
    end

    // ages stay dense and 0 is the newest entry.
    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            valid_q <= '0;
            for (int i = 0; i < RS_DEPTH; i++) begin
                age_q[i] <= '0;
            end
        end else begin
            for (int i = 0; i < RS_DEPTH; i++) begin
                if (valid_q[i]) begin
                    age_q[i] <= age_q[i] + IDX_W'(insert_i)
                                - IDX_W'(sel_valid && age_q[i] > sel_age);
                end
            end
            if (sel_valid) begin
                valid_q[sel_idx] <= 1'b0;
            end
            if (insert_i) begin
                valid_q[free_idx] <= 1'b1;
                age_q[free_idx]   <= '0;
            end
        end
    end

    // cdb wakeup.
    always_ff @(posedge clk) begin
        for (int i = 0; i < RS_DEPTH; i++) begin
            if (cdb_valid_i && entry_q[i].src1 == cdb_tag_i) begin
                entry_q[i].src1_rdy <= 1'b1;
            end
            if (cdb_valid_i && entry_q[i].src2 == cdb_tag_i) begin
                entry_q[i].src2_rdy <= 1'b1;
            end
        end
        if (insert_i) begin
            entry_q[free_idx] <= uop_i;
        end
    end

    assign rd_tag1_o      = entry_q[sel_idx].src1;
    assign rd_tag2_o      = entry_q[sel_idx].src2;
    assign issue_valid_o  = sel_valid;
    assign issue_op_o     = entry_q[sel_idx].op;
    assign issue_a_o      = rd_val1_i;
    assign issue_b_o      = entry_q[sel_idx].use_imm ? entry_q[sel_idx].imm : rd_val2_i;
    assign issue_rob_id_o = entry_q[sel_idx].rob_id;
    assign issue_tag_o    = entry_q[sel_idx].dst;

    a_no_insert_full: assert property (@(posedge clk) disable iff (!rst_n_i)
        insert_i |-> !full_o)
        else $error("station insert while full");

endmodule

// File: rtl/rename/id_stage.sv
`timescale 1ns/1ps

module id_stage
    import cpu_params::*;
    import uop_types::*;
(
    input  logic                clk,
    input  logic                rst_n_i,
    input  logic                fetch_valid_i,
    input  logic [31:0]         fetch_instr_i,
    output logic                fetch_ready_o,
    input  logic                fl_empty_i,
    input  logic [PHY_W-1:0]    fl_tag_i,
    output logic                fl_pop_o,
    input  logic                rob_full_i,
    input  logic [ROB_ID_W-1:0] rob_tail_i,
    output logic                rob_alloc_o,
    output logic [ARCH_W-1:0]   rob_rd_o,
    output logic [PHY_W-1:0]    rob_new_tag_o,
    output logic [PHY_W-1:0]    rob_old_tag_o,
    input  logic                rs_full_i,
    output logic                rs_insert_o,
    output uop_t                rs_uop_o,
    output logic [PHY_W-1:0]    src1_tag_o,
    output logic [PHY_W-1:0]    src2_tag_o,
    input  logic                src1_ready_i,
    input  logic                src2_ready_i,
    output logic [PHY_W-1:0]    alloc_tag_o
);

    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_LUI    = 7'b0110111;

    logic [PHY_W-1:0]  rat_q [ARCH_REGS];
    logic [6:0]        opcode;
    logic [2:0]        funct3;
    logic [6:0]        funct7;
    logic [ARCH_W-1:0] rs1;
    logic [ARCH_W-1:0] rs2;
    logic [ARCH_W-1:0] rd;
    logic              supported;
    logic              uses_rs1;
    logic              uses_rs2;
    logic              use_imm;
    logic              writes;
    logic              xfer;
    alu_op_e           op;
    logic [XLEN-1:0]   imm;
    logic [PHY_W-1:0]  dst_tag;

    assign opcode = fetch_instr_i[6:0];
    assign rd     = fetch_instr_i[11:7];
    assign funct3 = fetch_instr_i[14:12];
    assign rs1    = fetch_instr_i[19:15];
    assign rs2    = fetch_instr_i[24:20];
    assign funct7 = fetch_instr_i[31:25];

    // ********************
    // decode.
    always_comb begin
        op        = ALU_ADD;
        supported = 1'b1;
        uses_rs1  = 1'b1;
        uses_rs2  = 1'b0;
        use_imm   = 1'b1;
        imm       = {{20{fetch_instr_i[31]}}, fetch_instr_i[31:20]};
        case (funct3)
            3'b000: op = (opcode == OPC_OP && funct7[5]) ? ALU_SUB : ALU_ADD;
            3'b111: op = ALU_AND;
            3'b110: op = ALU_OR;
            3'b100: op = ALU_XOR;
            3'b010: op = ALU_SLT;
            default: supported = 1'b0;
        endcase
        case (opcode)
            OPC_OP: begin
                uses_rs2 = 1'b1;
                use_imm  = 1'b0;
                // only sub may set funct7.
                if (funct7 != 7'b0 && !(funct7 == 7'b0100000 && funct3 == 3'b000)) begin
                    supported = 1'b0;
                end
            end
            OPC_OP_IMM: begin
            end
            OPC_LUI: begin
                op        = ALU_LUI;
                supported = 1'b1;
                uses_rs1  = 1'b0;
                imm       = {fetch_instr_i[31:12], 12'b0};
            end
            default: supported = 1'b0;
        endcase
    end

    // ********************
    // rename and dispatch.
    assign writes        = supported && (rd != '0);
    assign dst_tag       = writes ? fl_tag_i : '0;
    assign src1_tag_o    = uses_rs1 ? rat_q[rs1] : '0;
    assign src2_tag_o    = uses_rs2 ? rat_q[rs2] : '0;
    assign fetch_ready_o = (!fl_empty_i || !writes) && !rob_full_i && !rs_full_i;
    assign xfer          = fetch_valid_i && fetch_ready_o;

    assign fl_pop_o      = xfer && writes;
    assign alloc_tag_o   = fl_tag_i;
    assign rob_alloc_o   = xfer;
    assign rob_rd_o      = writes ? rd : '0;
    assign rob_new_tag_o = dst_tag;
    assign rob_old_tag_o = writes ? rat_q[rd] : '0;
    // nothing to compute for x0 writes and no-ops.
    assign rs_insert_o   = xfer && writes;

    always_comb begin
        rs_uop_o          = '0;
        rs_uop_o.op       = op;
        rs_uop_o.rob_id   = rob_tail_i;
        rs_uop_o.dst      = dst_tag;
        rs_uop_o.src1     = src1_tag_o;
        rs_uop_o.src1_rdy = src1_ready_i;
        rs_uop_o.src2     = src2_tag_o;
        rs_uop_o.src2_rdy = src2_ready_i;
        rs_uop_o.imm      = imm;
        rs_uop_o.use_imm  = use_imm;
    end

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            for (int i = 0; i < ARCH_REGS; i++) begin
                rat_q[i] <= PHY_W'(i);
            end
        end else if (fl_pop_o) begin
            rat_q[rd] <= fl_tag_i;
        end
    end

endmodule

// File: rtl/rename/free_list.sv
`timescale 1ns/1ps

module free_list
    import cpu_params::*;
(
    input  logic             clk,
    input  logic             rst_n_i,
    input  logic             pop_i,
    output logic [PHY_W-1:0] tag_o,
    output logic             empty_o,
    input  logic             push_i,
    input  logic [PHY_W-1:0] push_tag_i
);

    localparam int FL_DEPTH = PHYS_REGS - ARCH_REGS;
    localparam int FL_W     = $clog2(FL_DEPTH);

    logic [PHY_W-1:0] tags_q [FL_DEPTH];
    logic [FL_W-1:0]  head_q;
    logic [FL_W-1:0]  tail_q;
    logic [FL_W:0]    count_q;

    assign tag_o   = tags_q[head_q];
    assign empty_o = (count_q == '0);

    // upper tags start free, lower ones back x0..x31.
    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            for (int i = 0; i < FL_DEPTH; i++) begin
                tags_q[i] <= PHY_W'(ARCH_REGS + i);
            end
            head_q  <= '0;
            tail_q  <= '0;
            count_q <= (FL_W + 1)'(FL_DEPTH);
        end else begin
            if (pop_i) begin
                head_q <= head_q + 1'b1;
            end
            if (push_i) begin
                tags_q[tail_q] <= push_tag_i;
                tail_q         <= tail_q + 1'b1;
            end
            count_q <= count_q + (FL_W + 1)'(push_i) - (FL_W + 1)'(pop_i);
        end
    end

    a_no_pop_empty: assert property (@(posedge clk) disable iff (!rst_n_i)
        pop_i |-> !empty_o)
        else $error("free list popped while empty");

    // a push past the depth means a tag was freed twice.
    a_no_push_full: assert property (@(posedge clk) disable iff (!rst_n_i)
        push_i |-> (count_q != (FL_W + 1)'(FL_DEPTH)))
        else $error("free list pushed while full");

endmodule

// File: common/uop_types.sv
package uop_types;

    import cpu_params::*;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLT,
        ALU_LUI
    } alu_op_e;

    // renamed micro-op as written into the station.
    typedef struct packed {
        alu_op_e             op;
        logic [ROB_ID_W-1:0] rob_id;
        logic [PHY_W-1:0]    dst;
        logic [PHY_W-1:0]    src1;
        logic                src1_rdy;
        logic [PHY_W-1:0]    src2;
        logic                src2_rdy;
        logic [XLEN-1:0]     imm;
        logic                use_imm;
    } uop_t;

endpackage

// File: common/cpu_params.sv
package cpu_params;

    // ********************
    // datapath and register file.
    localparam int XLEN      = 32;
    localparam int ARCH_REGS = 32;
    localparam int ARCH_W    = $clog2(ARCH_REGS);
    localparam int PHYS_REGS = 64;
    localparam int PHY_W     = $clog2(PHYS_REGS);

    // ********************
    // queue depths.
    localparam int ROB_DEPTH_DEF = 16;
    localparam int RS_DEPTH_DEF  = 8;
    // rob index sized for the deepest rob allowed.
    localparam int ROB_DEPTH_MAX = 16;
    localparam int ROB_ID_W      = $clog2(ROB_DEPTH_MAX);

endpackage
